// ==== hdl/nf_defines.svh ====
// Encodings and sizes shared by the core. Only word loads and stores exist,
// so the load and store funct3 fields are not decoded.
`ifndef NF_DEFINES_SVH
`define NF_DEFINES_SVH

// ####################################################################
`define NF_XLEN         32
`define NF_RESET_PC     32'h0000_0000

// Execute operand source selects.
`define HU_BP_NONE      2'b00
`define HU_BP_MEM       2'b01
`define HU_BP_WB        2'b10

// Branch type of the instruction in decode.
`define B_NONE          2'b00
`define B_EQ            2'b01
`define B_NE            2'b10

// ####################################################################
`define OP_R            7'b0110011
`define OP_I            7'b0010011
`define OP_LUI          7'b0110111
`define OP_LOAD         7'b0000011
`define OP_STORE        7'b0100011
`define OP_BRANCH       7'b1100011

// ALU operations carried from decode into execute.
`define ALU_ADD         3'd0
`define ALU_SUB         3'd1
`define ALU_AND         3'd2
`define ALU_OR          3'd3
`define ALU_XOR         3'd4
`define ALU_ADDI        3'd5        // Register plus immediate.
`define ALU_LUI         3'd6        // Immediate passes through.

`endif

// ==== hdl/nf_pkg.sv ====
// Types of the core. The instruction word is one union seen through the
// five base RV32I formats; J format is not supported.
`include "nf_defines.svh"

package nf_pkg;

    typedef logic [`NF_XLEN-1 : 0] word_t;
    typedef logic [4 : 0]          reg_idx_t;

    typedef struct packed {
        logic [6 : 0]   funct7;
        reg_idx_t       rs2;
        reg_idx_t       rs1;
        logic [2 : 0]   funct3;
        reg_idx_t       rd;
        logic [6 : 0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11 : 0]  imm_11_0;
        reg_idx_t       rs1;
        logic [2 : 0]   funct3;
        reg_idx_t       rd;
        logic [6 : 0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6 : 0]   imm_11_5;
        reg_idx_t       rs2;
        reg_idx_t       rs1;
        logic [2 : 0]   funct3;
        logic [4 : 0]   imm_4_0;
        logic [6 : 0]   opcode;
    } s_fmt_t;

    typedef struct packed {
        logic           imm_12;
        logic [5 : 0]   imm_10_5;
        reg_idx_t       rs2;
        reg_idx_t       rs1;
        logic [2 : 0]   funct3;
        logic [3 : 0]   imm_4_1;
        logic           imm_11;
        logic [6 : 0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19 : 0]  imm_31_12;
        reg_idx_t       rd;
        logic [6 : 0]   opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t     r_fmt;
        i_fmt_t     i_fmt;
        s_fmt_t     s_fmt;
        b_fmt_t     b_fmt;
        u_fmt_t     u_fmt;
    } instr_t;

endpackage : nf_pkg

// ==== hdl/nf_fetch_stage.sv ====
// Fetch stage. The instruction bus is sampled only in cycles without a
// stall, so instr is ignored while the instruction ack is low.
`timescale 1ns/1ns
`include "nf_defines.svh"

module nf_fetch_stage
    import nf_pkg::*;
(
    input   logic       clk,
    input   logic       reset,
    input   logic       stall_if,
    input   logic       stall_id,
    input   logic       branch_taken,
    input   word_t      branch_target,
    input   word_t      instr,
    output  word_t      instr_addr,
    output  instr_t     instr_id,
    output  word_t      pc_id
);

    localparam word_t NOP = 32'h0000_0013;     // addi x0, x0, 0.

    word_t  pc;

    assign instr_addr = pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= `NF_RESET_PC;
        else if (!stall_if)
            pc <= branch_taken ? branch_target : pc + 32'd4;
    end

    // The word fetched behind a taken branch is replaced by a NOP.
    always_ff @(posedge clk)
    begin
        if (reset)
            instr_id <= NOP;
        else if (!stall_id)
            instr_id <= branch_taken ? NOP : instr;
    end

    always_ff @(posedge clk)
    begin
        if (!stall_id)
            pc_id <= pc;                        // Base of the branch target.
    end

endmodule : nf_fetch_stage

// ==== hdl/nf_decode_stage.sv ====
// Decode stage with register file and branch resolution. Unsupported
// encodings decode as NOPs. Writes to x0 are dropped here.
`timescale 1ns/1ns
`include "nf_defines.svh"

module nf_decode_stage
    import nf_pkg::*;
(
    input   logic           clk,
    input   logic           reset,
    input   instr_t         instr_id,
    input   word_t          pc_id,
    input   logic           stall_id,
    input   logic           stall_iexe,
    input   logic           flush_iexe,
    input   reg_idx_t       wa3_iwb,
    input   logic           we_rf_iwb,
    input   word_t          wd_iwb,
    input   word_t          wd_imem,
    input   logic           cmp_d1_bypass,
    input   logic           cmp_d2_bypass,
    output  reg_idx_t       ra1_id,
    output  reg_idx_t       ra2_id,
    output  logic [1 : 0]   branch_type,
    output  logic           branch_taken,
    output  word_t          branch_target,
    output  reg_idx_t       ra1_iexe,
    output  reg_idx_t       ra2_iexe,
    output  word_t          rd1_iexe,
    output  word_t          rd2_iexe,
    output  word_t          imm_iexe,
    output  logic [2 : 0]   alu_op_iexe,
    output  reg_idx_t       wa3_iexe,
    output  logic           we_rf_iexe,
    output  logic           rf_src_iexe,
    output  logic           we_dm_iexe
);

    word_t          reg_file [32];
    word_t          rd1_id, rd2_id, imm_id;
    word_t          cmp_a, cmp_b;
    logic [2 : 0]   alu_op_id;
    logic           we_rf_id, rf_src_id, we_dm_id;

    assign ra1_id = instr_id.r_fmt.rs1;
    assign ra2_id = instr_id.r_fmt.rs2;

    // Write-back goes through, so a same-cycle read sees it.
    function automatic word_t rf_read(reg_idx_t ra);
        if (ra == 5'd0)
            return '0;
        if (we_rf_iwb && (ra == wa3_iwb))
            return wd_iwb;
        return reg_file[ra];
    endfunction

    always_ff @(posedge clk)
    begin
        if (we_rf_iwb && (wa3_iwb != 5'd0))
            reg_file[wa3_iwb] <= wd_iwb;
    end

    always_comb
    begin
        rd1_id = rf_read(ra1_id);
        rd2_id = rf_read(ra2_id);
    end

    // ####################################################################
    always_comb
    begin
        alu_op_id   = `ALU_ADDI;
        imm_id      = {{20{instr_id.i_fmt.imm_11_0[11]}}, instr_id.i_fmt.imm_11_0};
        we_rf_id    = 1'b0;
        rf_src_id   = 1'b0;
        we_dm_id    = 1'b0;
        branch_type = `B_NONE;
        case (instr_id.r_fmt.opcode)
            `OP_R:
            begin
                we_rf_id = 1'b1;
                case (instr_id.r_fmt.funct3)
                    3'b000:  alu_op_id = instr_id.r_fmt.funct7[5] ? `ALU_SUB : `ALU_ADD;
                    3'b100:  alu_op_id = `ALU_XOR;
                    3'b110:  alu_op_id = `ALU_OR;
                    3'b111:  alu_op_id = `ALU_AND;
                    default: we_rf_id  = 1'b0;
                endcase
            end
            `OP_I:      we_rf_id = (instr_id.i_fmt.funct3 == 3'b000);   // ADDI only.
            `OP_LUI:
            begin
                alu_op_id = `ALU_LUI;
                imm_id    = {instr_id.u_fmt.imm_31_12, 12'b0};
                we_rf_id  = 1'b1;
            end
            `OP_LOAD:
            begin
                we_rf_id  = 1'b1;
                rf_src_id = 1'b1;               // Result comes from memory.
            end
            `OP_STORE:
            begin
                imm_id   = {{20{instr_id.s_fmt.imm_11_5[6]}}, instr_id.s_fmt.imm_11_5,
                            instr_id.s_fmt.imm_4_0};
                we_dm_id = 1'b1;
            end
            `OP_BRANCH:
            begin
                if (instr_id.b_fmt.funct3 == 3'b000)
                    branch_type = `B_EQ;
                else if (instr_id.b_fmt.funct3 == 3'b001)
                    branch_type = `B_NE;
            end
            default: ;
        endcase
        if (instr_id.r_fmt.rd == 5'd0)
            we_rf_id = 1'b0;
    end

    // Comparator with bypass from the memory stage.
    assign cmp_a = cmp_d1_bypass ? wd_imem : rd1_id;
    assign cmp_b = cmp_d2_bypass ? wd_imem : rd2_id;

    assign branch_target = pc_id + {{19{instr_id.b_fmt.imm_12}}, instr_id.b_fmt.imm_12,
                                    instr_id.b_fmt.imm_11, instr_id.b_fmt.imm_10_5,
                                    instr_id.b_fmt.imm_4_1, 1'b0};
    assign branch_taken  = !stall_id &&
                           (((branch_type == `B_EQ) && (cmp_a == cmp_b)) ||
                            ((branch_type == `B_NE) && (cmp_a != cmp_b)));

    // ####################################################################
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            we_rf_iexe  <= 1'b0;
            rf_src_iexe <= 1'b0;
            we_dm_iexe  <= 1'b0;
        end
        else if (!stall_iexe)
        begin
            we_rf_iexe  <= we_rf_id  && !flush_iexe;    // Bubble on flush.
            rf_src_iexe <= rf_src_id && !flush_iexe;
            we_dm_iexe  <= we_dm_id  && !flush_iexe;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_iexe)
        begin
            ra1_iexe    <= ra1_id;
            ra2_iexe    <= ra2_id;
            rd1_iexe    <= rd1_id;
            rd2_iexe    <= rd2_id;
            imm_iexe    <= imm_id;
            alu_op_iexe <= alu_op_id;
            wa3_iexe    <= instr_id.r_fmt.rd;
        end
    end

endmodule : nf_decode_stage

// ==== hdl/nf_execute_stage.sv ====
// Execute stage. Operands come from decode, memory or write-back as the
// hazard unit selects; store data takes the same bypass as operand two.
`timescale 1ns/1ns
`include "nf_defines.svh"

module nf_execute_stage
    import nf_pkg::*;
(
    input   logic           clk,
    input   logic           reset,
    input   word_t          rd1_iexe,
    input   word_t          rd2_iexe,
    input   word_t          imm_iexe,
    input   logic [2 : 0]   alu_op_iexe,
    input   reg_idx_t       wa3_iexe,
    input   logic           we_rf_iexe,
    input   logic           rf_src_iexe,
    input   logic           we_dm_iexe,
    input   logic [1 : 0]   rd1_bypass,
    input   logic [1 : 0]   rd2_bypass,
    input   word_t          wd_imem,
    input   word_t          wd_iwb,
    input   logic           stall_imem,
    output  word_t          alu_res_imem,
    output  word_t          wdata_imem,
    output  reg_idx_t       wa3_imem,
    output  logic           we_rf_imem,
    output  logic           rf_src_imem,
    output  logic           we_dm_imem
);

    word_t  src_a, src_b, alu_res;

    function automatic word_t bypass(logic [1 : 0] sel, word_t rf_val);
        case (sel)
            `HU_BP_MEM: return wd_imem;
            `HU_BP_WB:  return wd_iwb;
            default:    return rf_val;
        endcase
    endfunction

    always_comb
    begin
        src_a = bypass(rd1_bypass, rd1_iexe);
        src_b = bypass(rd2_bypass, rd2_iexe);
        case (alu_op_iexe)
            `ALU_SUB:  alu_res = src_a - src_b;
            `ALU_AND:  alu_res = src_a & src_b;
            `ALU_OR:   alu_res = src_a | src_b;
            `ALU_XOR:  alu_res = src_a ^ src_b;
            `ALU_ADDI: alu_res = src_a + imm_iexe;     // Also load/store address.
            `ALU_LUI:  alu_res = imm_iexe;
            default:   alu_res = src_a + src_b;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            we_rf_imem  <= 1'b0;
            rf_src_imem <= 1'b0;
            we_dm_imem  <= 1'b0;
        end
        else if (!stall_imem)
        begin
            we_rf_imem  <= we_rf_iexe;
            rf_src_imem <= rf_src_iexe;
            we_dm_imem  <= we_dm_iexe;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_imem)
        begin
            alu_res_imem <= alu_res;
            wdata_imem   <= src_b;
            wa3_imem     <= wa3_iexe;
        end
    end

endmodule : nf_execute_stage

// ==== hdl/nf_memory_stage.sv ====
// Memory stage. The data request stays up until the ack; the hazard unit
// holds the pipe meanwhile, so load data is used in the ack cycle only.
`timescale 1ns/1ns

module nf_memory_stage
    import nf_pkg::*;
(
    input   logic       clk,
    input   logic       reset,
    input   word_t      alu_res_imem,
    input   word_t      wdata_imem,
    input   reg_idx_t   wa3_imem,
    input   logic       we_rf_imem,
    input   logic       rf_src_imem,
    input   logic       we_dm_imem,
    input   word_t      data_rdata,
    input   logic       stall_iwb,
    output  logic       data_req,
    output  logic       data_we,
    output  word_t      data_addr,
    output  word_t      data_wdata,
    output  word_t      wd_imem,
    output  reg_idx_t   wa3_iwb,
    output  logic       we_rf_iwb,
    output  word_t      wd_iwb
);

    assign data_req   = rf_src_imem || we_dm_imem;      // Any LW or SW.
    assign data_we    = we_dm_imem;
    assign data_addr  = alu_res_imem;
    assign data_wdata = wdata_imem;
    assign wd_imem    = rf_src_imem ? data_rdata : alu_res_imem;

    // Write-back keeps its entry while a request waits, which keeps
    // its bypass valid for the instruction held in execute.
    always_ff @(posedge clk)
    begin
        if (reset)
            we_rf_iwb <= 1'b0;
        else if (!stall_iwb)
            we_rf_iwb <= we_rf_imem;
    end

    always_ff @(posedge clk)
    begin
        if (!stall_iwb)
        begin
            wa3_iwb <= wa3_imem;
            wd_iwb  <= wd_imem;
        end
    end

endmodule : nf_memory_stage

// ==== hdl/nf_hazard_unit.sv ====
// Forwarding, stall and flush control. A missing instruction ack freezes
// fetch and decode and lets the older instructions drain.
`timescale 1ns/1ns
`include "nf_defines.svh"

module nf_hazard_unit
    import nf_pkg::*;
(
    // Forwarding.
    input   reg_idx_t       wa3_imem,
    input   logic           we_rf_imem,
    input   reg_idx_t       wa3_iwb,
    input   logic           we_rf_iwb,
    input   reg_idx_t       ra1_iexe,
    input   reg_idx_t       ra2_iexe,
    output  logic [1 : 0]   rd1_bypass,
    output  logic [1 : 0]   rd2_bypass,
    output  logic           cmp_d1_bypass,
    output  logic           cmp_d2_bypass,
    // Stalls and flush.
    input   reg_idx_t       wa3_iexe,
    input   logic           we_rf_iexe,
    input   logic           rf_src_iexe,
    input   reg_idx_t       ra1_id,
    input   reg_idx_t       ra2_id,
    output  logic           stall_if,
    output  logic           stall_id,
    output  logic           stall_iexe,
    output  logic           stall_imem,
    output  logic           stall_iwb,
    output  logic           flush_iexe,
    input   logic [1 : 0]   branch_type,
    input   logic           we_dm_imem,
    input   logic           req_ack_dm,
    input   logic           req_ack_i,
    input   logic           rf_src_imem
);

    logic   lw_stall;
    logic   dm_stall;
    logic   branch_stall;
    logic   instr_stall;

    assign cmp_d1_bypass = (wa3_imem == ra1_id) && we_rf_imem;
    assign cmp_d2_bypass = (wa3_imem == ra2_id) && we_rf_imem;

    // Memory wins over write-back, being the younger result.
    always_comb
    begin
        rd1_bypass = `HU_BP_NONE;
        rd2_bypass = `HU_BP_NONE;
        if ((wa3_imem == ra1_iexe) && we_rf_imem)
            rd1_bypass = `HU_BP_MEM;
        else if ((wa3_iwb == ra1_iexe) && we_rf_iwb)
            rd1_bypass = `HU_BP_WB;
        if ((wa3_imem == ra2_iexe) && we_rf_imem)
            rd2_bypass = `HU_BP_MEM;
        else if ((wa3_iwb == ra2_iexe) && we_rf_iwb)
            rd2_bypass = `HU_BP_WB;
    end

    // ####################################################################
    assign lw_stall     = ((ra1_id == wa3_iexe) || (ra2_id == wa3_iexe)) &&
                          we_rf_iexe && rf_src_iexe;
    assign branch_stall = (branch_type != `B_NONE) && we_rf_iexe &&
                          ((wa3_iexe == ra1_id) || (wa3_iexe == ra2_id));
    assign dm_stall     = (rf_src_imem || we_dm_imem) && !req_ack_dm;
    assign instr_stall  = !req_ack_i;

    assign stall_if   = lw_stall || dm_stall || branch_stall || instr_stall;
    assign stall_id   = stall_if;
    assign flush_iexe = lw_stall || branch_stall || instr_stall;   // Hold outranks it.
    assign stall_iexe = dm_stall;
    assign stall_imem = dm_stall;
    assign stall_iwb  = dm_stall;

endmodule : nf_hazard_unit

// ==== hdl/nf_cpu.sv ====
// Top level of the five-stage core. Both memories live outside and answer
// with an ack level; requests are held until that ack.
`timescale 1ns/1ns

module nf_cpu
    import nf_pkg::*;
(
    input   logic   clk,
    input   logic   reset,
    output  word_t  instr_addr,
    input   word_t  instr,
    input   logic   req_ack_i,
    output  logic   data_req,
    output  logic   data_we,
    output  word_t  data_addr,
    output  word_t  data_wdata,
    input   word_t  data_rdata,
    input   logic   req_ack_dm
);

    instr_t         instr_id;
    word_t          pc_id, branch_target;
    logic           branch_taken;
    logic [1 : 0]   branch_type;
    reg_idx_t       ra1_id, ra2_id;
    // Execute stage.
    reg_idx_t       ra1_iexe, ra2_iexe, wa3_iexe;
    word_t          rd1_iexe, rd2_iexe, imm_iexe;
    logic [2 : 0]   alu_op_iexe;
    logic           we_rf_iexe, rf_src_iexe, we_dm_iexe;
    // Memory and write-back stages.
    word_t          alu_res_imem, wdata_imem, wd_imem, wd_iwb;
    reg_idx_t       wa3_imem, wa3_iwb;
    logic           we_rf_imem, rf_src_imem, we_dm_imem, we_rf_iwb;
    // Hazard control.
    logic [1 : 0]   rd1_bypass, rd2_bypass;
    logic           cmp_d1_bypass, cmp_d2_bypass;
    logic           stall_if, stall_id, stall_iexe, stall_imem, stall_iwb;
    logic           flush_iexe;

    nf_fetch_stage fetch0 (
        .clk(clk), .reset(reset), .stall_if(stall_if), .stall_id(stall_id),
        .branch_taken(branch_taken), .branch_target(branch_target), .instr(instr),
        .instr_addr(instr_addr), .instr_id(instr_id), .pc_id(pc_id)
    );

    nf_decode_stage decode0 (
        .clk(clk), .reset(reset), .instr_id(instr_id), .pc_id(pc_id),
        .stall_id(stall_id), .stall_iexe(stall_iexe), .flush_iexe(flush_iexe),
        .wa3_iwb(wa3_iwb), .we_rf_iwb(we_rf_iwb), .wd_iwb(wd_iwb), .wd_imem(wd_imem),
        .cmp_d1_bypass(cmp_d1_bypass), .cmp_d2_bypass(cmp_d2_bypass),
        .ra1_id(ra1_id), .ra2_id(ra2_id), .branch_type(branch_type),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .ra1_iexe(ra1_iexe), .ra2_iexe(ra2_iexe), .rd1_iexe(rd1_iexe),
        .rd2_iexe(rd2_iexe), .imm_iexe(imm_iexe), .alu_op_iexe(alu_op_iexe),
        .wa3_iexe(wa3_iexe), .we_rf_iexe(we_rf_iexe), .rf_src_iexe(rf_src_iexe),
        .we_dm_iexe(we_dm_iexe)
    );

    nf_execute_stage execute0 (
        .clk(clk), .reset(reset), .rd1_iexe(rd1_iexe), .rd2_iexe(rd2_iexe),
        .imm_iexe(imm_iexe), .alu_op_iexe(alu_op_iexe), .wa3_iexe(wa3_iexe),
        .we_rf_iexe(we_rf_iexe), .rf_src_iexe(rf_src_iexe), .we_dm_iexe(we_dm_iexe),
        .rd1_bypass(rd1_bypass), .rd2_bypass(rd2_bypass), .wd_imem(wd_imem),
        .wd_iwb(wd_iwb), .stall_imem(stall_imem), .alu_res_imem(alu_res_imem),
        .wdata_imem(wdata_imem), .wa3_imem(wa3_imem), .we_rf_imem(we_rf_imem),
        .rf_src_imem(rf_src_imem), .we_dm_imem(we_dm_imem)
    );

    nf_memory_stage memory0 (
        .clk(clk), .reset(reset), .alu_res_imem(alu_res_imem), .wdata_imem(wdata_imem),
        .wa3_imem(wa3_imem), .we_rf_imem(we_rf_imem), .rf_src_imem(rf_src_imem),
        .we_dm_imem(we_dm_imem), .data_rdata(data_rdata), .stall_iwb(stall_iwb),
        .data_req(data_req), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .wd_imem(wd_imem), .wa3_iwb(wa3_iwb),
        .we_rf_iwb(we_rf_iwb), .wd_iwb(wd_iwb)
    );

    nf_hazard_unit hazard0 (
        .wa3_imem(wa3_imem), .we_rf_imem(we_rf_imem), .wa3_iwb(wa3_iwb),
        .we_rf_iwb(we_rf_iwb), .ra1_iexe(ra1_iexe), .ra2_iexe(ra2_iexe),
        .rd1_bypass(rd1_bypass), .rd2_bypass(rd2_bypass),
        .cmp_d1_bypass(cmp_d1_bypass), .cmp_d2_bypass(cmp_d2_bypass),
        .wa3_iexe(wa3_iexe), .we_rf_iexe(we_rf_iexe), .rf_src_iexe(rf_src_iexe),
        .ra1_id(ra1_id), .ra2_id(ra2_id), .stall_if(stall_if), .stall_id(stall_id),
        .stall_iexe(stall_iexe), .stall_imem(stall_imem), .stall_iwb(stall_iwb),
        .flush_iexe(flush_iexe), .branch_type(branch_type), .we_dm_imem(we_dm_imem),
        .req_ack_dm(req_ack_dm), .req_ack_i(req_ack_i), .rf_src_imem(rf_src_imem)
    );

endmodule : nf_cpu

// ==== test/nf_tb_mem.sv ====
// Instruction ROM and data RAM of 64 words each; addresses wrap on bits 7:2.
// Outputs change on the falling edge. A store counts when its ack is given.
`timescale 1ns/1ns

module nf_tb_mem
    import nf_pkg::*;
(
    input   logic       clk,
    input   logic       reset,
    input   logic       rnd_en,
    input   word_t      instr_addr,
    output  word_t      instr,
    output  logic       req_ack_i,
    input   logic       data_req,
    input   logic       data_we,
    input   word_t      data_addr,
    input   word_t      data_wdata,
    output  word_t      data_rdata,
    output  logic       req_ack_dm,
    output  logic       st_valid,
    output  word_t      st_addr,
    output  word_t      st_data
);

    word_t  rom [64];
    word_t  ram [64];
    integer seed;
    int     i_wait;
    int     d_wait;
    logic   d_busy;
    logic   d_ack;

    // Cycles to withhold the next ack, 0 to 3.
    function automatic int draw_delay();
        if (!rnd_en)
            return 0;
        return int'($unsigned($random(seed)) % 32'd4);
    endfunction

    initial
    begin
        seed       = 32'h8f3f_9155;
        instr      = 32'h0000_0013;
        req_ack_i  = 1'b0;
        data_rdata = '0;
        req_ack_dm = 1'b0;
        st_valid   = 1'b0;
        st_addr    = '0;
        st_data    = '0;
        i_wait     = 0;
        d_wait     = 0;
        d_busy     = 1'b0;
    end

    always @(negedge clk)
    begin
        instr <= rom[instr_addr[7:2]];
        d_ack = 1'b0;
        if (reset)
        begin
            i_wait = 0;
            d_busy = 1'b0;
            req_ack_i <= 1'b0;
        end
        else
        begin
            // ################################################################
            if (i_wait > 0)
            begin
                req_ack_i <= 1'b0;
                i_wait = i_wait - 1;
            end
            else
            begin
                req_ack_i <= 1'b1;
                i_wait = draw_delay();                // Delay of the next fetch.
            end
            // ################################################################
            if (data_req)
            begin
                if (!d_busy)
                begin
                    d_wait = draw_delay();
                    d_busy = 1'b1;
                end
                if (d_wait == 0)
                begin
                    d_ack  = 1'b1;
                    d_busy = 1'b0;
                end
                else
                    d_wait = d_wait - 1;
            end
        end
        req_ack_dm <= d_ack;
        data_rdata <= ram[data_addr[7:2]];
        st_valid   <= d_ack && data_we;           // DUT holds the store to the edge.
        st_addr    <= data_addr;
        st_data    <= data_wdata;
        if (d_ack && data_we)
            ram[data_addr[7:2]] = data_wdata;
    end

endmodule : nf_tb_mem

// ==== test/nf_cpu_tb.sv ====
// Runs each program of the table from reset and checks its ordered store
// list. Rows 3 to 5 repeat rows 0 to 2 with random ack delays.
`timescale 1ns/1ns
`include "nf_defines.svh"

module nf_cpu_tb
    import nf_pkg::*;
();

    localparam int ROWS = 6;

    logic   clk;
    logic   reset;
    logic   rnd_en;
    word_t  instr_addr, instr, data_addr, data_wdata, data_rdata;
    logic   req_ack_i, data_req, data_we, req_ack_dm;
    logic   st_valid;
    word_t  st_addr, st_data;

    instr_t prog [ROWS][12];
    int     prog_len [ROWS];
    logic   rnd_flag [ROWS];
    word_t  exp_addr [ROWS][4];
    word_t  exp_data [ROWS][4];
    int     exp_n [ROWS];
    int     cur_row, st_idx, cycles, limit;

    nf_cpu dut0 (
        .clk(clk), .reset(reset), .instr_addr(instr_addr), .instr(instr),
        .req_ack_i(req_ack_i), .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_rdata(data_rdata),
        .req_ack_dm(req_ack_dm)
    );

    nf_tb_mem mem0 (
        .clk(clk), .reset(reset), .rnd_en(rnd_en), .instr_addr(instr_addr),
        .instr(instr), .req_ack_i(req_ack_i), .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_rdata(data_rdata),
        .req_ack_dm(req_ack_dm), .st_valid(st_valid), .st_addr(st_addr),
        .st_data(st_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ####################################################################
    function automatic instr_t enc_r(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, reg_idx_t rs2);
        instr_t w;
        w.r_fmt = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: `OP_R};
        return w;
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_idx_t rs1, reg_idx_t rd,
                                     logic [6:0] op);
        instr_t         w;
        logic [2 : 0]   f3;
        f3 = (op == `OP_LOAD) ? 3'b010 : 3'b000;        // LW or ADDI.
        w.i_fmt = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: op};
        return w;
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        instr_t w;
        w.s_fmt = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010,
                    imm_4_0: imm[4:0], opcode: `OP_STORE};
        return w;
    endfunction

    function automatic instr_t enc_b(logic [12:0] off, logic [2:0] f3, reg_idx_t rs1,
                                     reg_idx_t rs2);
        instr_t w;
        w.b_fmt = '{imm_12: off[12], imm_10_5: off[10:5], rs2: rs2, rs1: rs1,
                    funct3: f3, imm_4_1: off[4:1], imm_11: off[11], opcode: `OP_BRANCH};
        return w;
    endfunction

    function automatic instr_t enc_u(logic [19:0] imm, reg_idx_t rd);
        instr_t w;
        w.u_fmt = '{imm_31_12: imm, rd: rd, opcode: `OP_LUI};
        return w;
    endfunction

    task automatic put(int row, instr_t w);
        prog[row][prog_len[row]] = w;
        prog_len[row]++;
    endtask

    task automatic expect_store(int row, word_t addr, word_t data);
        exp_addr[row][exp_n[row]] = addr;
        exp_data[row][exp_n[row]] = data;
        exp_n[row]++;
    endtask

    task automatic fail_now();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    // ####################################################################
    task automatic build_table();
        for (int r = 0; r < ROWS; r++)
        begin
            prog_len[r] = 0;
            exp_n[r]    = 0;
            rnd_flag[r] = (r >= 3);
        end
        // Forwarding from memory and write-back.
        put(0, enc_i(12'd5, 5'd0, 5'd1, `OP_I));
        put(0, enc_i(12'd7, 5'd0, 5'd2, `OP_I));
        put(0, enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));    // x3 = 12.
        put(0, enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));    // x4 = 7.
        put(0, enc_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd3));    // x5 = 11.
        put(0, enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));    // x6 = 15.
        put(0, enc_s(12'd0, 5'd6, 5'd0));
        put(0, enc_r(7'h00, 3'b111, 5'd7, 5'd6, 5'd4));    // x7 = 7.
        put(0, enc_u(20'h12345, 5'd8));
        put(0, enc_s(12'd4, 5'd8, 5'd0));
        put(0, enc_s(12'd8, 5'd7, 5'd0));
        put(0, enc_b(13'd0, 3'b000, 5'd0, 5'd0));
        expect_store(0, 32'd0, 32'd15);
        expect_store(0, 32'd4, 32'h1234_5000);
        expect_store(0, 32'd8, 32'd7);
        // Load-use into ALU and into store data.
        put(1, enc_i(12'd100, 5'd0, 5'd1, `OP_I));
        put(1, enc_i(12'd23, 5'd0, 5'd2, `OP_I));
        put(1, enc_s(12'd16, 5'd1, 5'd0));
        put(1, enc_i(12'd16, 5'd0, 5'd3, `OP_LOAD));
        put(1, enc_r(7'h00, 3'b000, 5'd4, 5'd3, 5'd2));    // x4 = 123.
        put(1, enc_s(12'd20, 5'd4, 5'd0));
        put(1, enc_i(12'd20, 5'd0, 5'd5, `OP_LOAD));
        put(1, enc_s(12'd24, 5'd5, 5'd0));
        put(1, enc_b(13'd0, 3'b000, 5'd0, 5'd0));
        expect_store(1, 32'd16, 32'd100);
        expect_store(1, 32'd20, 32'd123);
        expect_store(1, 32'd24, 32'd123);
        // Branches; the stores at words 3 and 8 sit in squashed slots.
        put(2, enc_i(12'd3, 5'd0, 5'd1, `OP_I));
        put(2, enc_i(12'd3, 5'd0, 5'd2, `OP_I));
        put(2, enc_b(13'd8, 3'b000, 5'd1, 5'd2));          // Taken after stall and bypass.
        put(2, enc_s(12'd0, 5'd1, 5'd0));
        put(2, enc_b(13'd8, 3'b001, 5'd1, 5'd2));          // Not taken.
        put(2, enc_s(12'd4, 5'd2, 5'd0));
        put(2, enc_i(12'd9, 5'd0, 5'd3, `OP_I));
        put(2, enc_b(13'd8, 3'b001, 5'd3, 5'd1));          // Taken.
        put(2, enc_s(12'd8, 5'd3, 5'd0));
        put(2, enc_b(13'd8, 3'b000, 5'd3, 5'd1));          // Not taken.
        put(2, enc_s(12'd12, 5'd3, 5'd0));
        put(2, enc_b(13'd0, 3'b000, 5'd0, 5'd0));
        expect_store(2, 32'd4, 32'd3);
        expect_store(2, 32'd12, 32'd9);
        for (int r = 3; r < ROWS; r++)
        begin
            prog[r]     = prog[r - 3];
            prog_len[r] = prog_len[r - 3];
            exp_addr[r] = exp_addr[r - 3];
            exp_data[r] = exp_data[r - 3];
            exp_n[r]    = exp_n[r - 3];
        end
    endtask

    task automatic run_row(int row);
        @(negedge clk);
        reset  = 1'b1;
        rnd_en = rnd_flag[row];
        for (int i = 0; i < 64; i++)
        begin
            mem0.rom[i] = (i < prog_len[row]) ? prog[row][i] : 32'h0000_0013;
            mem0.ram[i] = {24'h5a5a5a, i[5:0], 2'b00};
        end
        cur_row = row;
        st_idx  = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("data_req", data_req, 1'b0);
        check_bit("data_we", data_we, 1'b0);
        check_word("instr_addr", instr_addr, `NF_RESET_PC);
        reset = 1'b0;
        while (st_idx < exp_n[row])
            @(negedge clk);
        repeat (10) @(negedge clk);                        // Catch late extra stores.
    endtask

    // Stores are compared in order as the memory model reports them.
    always @(posedge clk)
    begin
        if (!reset && st_valid)
        begin
            if (st_idx >= exp_n[cur_row])
            begin
                $display("Unexpected extra store to %h in row %0d", st_addr, cur_row);
                fail_now();
            end
            else
            begin
                check_word("data_addr", st_addr, exp_addr[cur_row][st_idx]);
                check_word("data_wdata", st_data, exp_data[cur_row][st_idx]);
                st_idx++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("Timeout after %0d cycles, stores missing in row %0d", cycles, cur_row);
            fail_now();
        end
    end

    initial
    begin
        int total;
        reset   = 1'b1;
        rnd_en  = 1'b0;
        cycles  = 0;
        cur_row = 0;
        st_idx  = 0;
        total   = 0;
        build_table();
        for (int r = 0; r < ROWS; r++)
            total += prog_len[r];
        limit = 16 * total + 200;
        for (int r = 0; r < ROWS; r++)
            run_row(r);
        $display("Verification passed");
        $finish;
    end

endmodule : nf_cpu_tb

// ==== flist.f ====
+incdir+hdl
hdl/nf_pkg.sv
hdl/nf_fetch_stage.sv
hdl/nf_decode_stage.sv
hdl/nf_execute_stage.sv
hdl/nf_memory_stage.sv
hdl/nf_hazard_unit.sv
hdl/nf_cpu.sv
test/nf_tb_mem.sv
test/nf_cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= nf_cpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
